// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= cache_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_req_decode.sv
verilog/cache_way_store.sv
verilog/cache_hit_check.sv
verilog/cache_word_io.sv
verilog/cache_control.sv
verilog/cache_top.sv
sim/cache_tb.sv

// ==== sim/cache_input.txt ====
# columns: name op address rmask wmask wdata expected_rdata expected_writeback_address
# ops: rm clean read miss, rw dirty read miss, rh read hit, wm write miss, wh write hit
# set 1, fill, hit, byte merge
rd_miss_a      rm 12345024 f 0 00000000 12345024 00000000
rd_hit_a       rh 12345024 6 0 00000000 00345000 00000000
wr_hit_a       wh 12345024 0 5 aabbccdd 00000000 00000000
rd_merged_a    rh 12345024 f 0 00000000 12bb50dd 00000000
# set 2, five tags with clean lines
fill_b0        rm 10000048 f 0 00000000 10000048 00000000
fill_b1        rm 20000048 f 0 00000000 20000048 00000000
fill_b2        rm 30000048 8 0 00000000 30000000 00000000
fill_b3        rm 40000048 3 0 00000000 00000048 00000000
evict_b0       rm 50000048 f 0 00000000 50000048 00000000
hit_b1         rh 20000048 f 0 00000000 20000048 00000000
reread_b0      rm 10000048 f 0 00000000 10000048 00000000
hit_b4         rh 50000048 c 0 00000000 50000000 00000000
# set 1 again, dirty line of a gets evicted
fill_c1        rm 60000024 f 0 00000000 60000024 00000000
fill_c2        rm 70000024 f 0 00000000 70000024 00000000
fill_c3        rm 80000024 f 0 00000000 80000024 00000000
evict_dirty_a  rw 90000024 f 0 00000000 90000024 12345020
reread_a       rm 12345024 f 0 00000000 12bb50dd 00000000
# set 3, write miss then hits on the filled line
wr_miss_d      wm cafe0068 0 f 11223344 00000000 00000000
rd_hit_d       rh cafe0068 f 0 00000000 11223344 00000000
rd_hit_d_low   rh cafe0064 1 0 00000000 00000064 00000000

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int    CLK_HALF        = 5;
    localparam int    RESET_CYCLES    = 4;
    // cycles from a memory request rising to its dfp_resp
    localparam int    MEM_DELAY       = 3;
    localparam int    CYCLES_PER_TEST = 200;
    localparam string VEC_FILE        = "sim/cache_input.txt";

    // one vector with request, expected read word and expected write-back address
    typedef struct packed {
        cache_req_t  req;
        logic [31:0] rdata;
        logic [31:0] wbaddr;
    } test_vec_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic [31:0]              ufp_addr;
    logic [3:0]               ufp_rmask;
    logic [3:0]               ufp_wmask;
    logic [31:0]              ufp_wdata;
    logic [31:0]              ufp_rdata;
    logic                     ufp_resp;
    logic [31:0]              dfp_addr;
    logic                     dfp_read;
    logic                     dfp_write;
    logic [`CACHE_LINE_W-1:0] dfp_rdata = '0;
    logic [`CACHE_LINE_W-1:0] dfp_wdata;
    logic                     dfp_resp = 1'b0;

    // written-back lines by line address
    logic [`CACHE_LINE_W-1:0] wb_lines [logic [31:0]];
    logic [31:0]              last_wb_addr = '0;
    int                       mem_age = 0;
    int                       fill_count = 0;
    int                       wb_count = 0;

    test_vec_t vecs  [$];
    string     names [$];
    string     ops   [$];
    bit        vectors_loaded = 1'b0;
    int        errors = 0;
    int        checks = 0;
    int        tests_run = 0;
    int        failed_tests = 0;

    cache_top cache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_rdata (ufp_rdata),
        .ufp_wdata (ufp_wdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_rdata (dfp_rdata),
        .dfp_wdata (dfp_wdata),
        .dfp_resp  (dfp_resp)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    // packed $sscanf token to text without its leading nulls
    function automatic string token_text(input logic [8*32-1:0] tok);
        string      s;
        logic [7:0] ch;
        s = "";
        for (int i = 31; i >= 0; i--) begin
            ch = tok[i*8 +: 8];
            if (ch != 8'h00) begin
                s = {s, $sformatf("%c", ch)};
            end
        end
        return s;
    endfunction

    // 2 cycles per hit lookup plus MEM_DELAY per memory transfer
    function automatic int expected_latency(input string op);
        if (op == "rh" || op == "wh") begin
            return 2;
        end else if (op == "rm" || op == "wm") begin
            return 2 + MEM_DELAY + 2;
        end else if (op == "rw") begin
            return 2 + 2 * MEM_DELAY + 2;
        end
        return -1;
    endfunction

    function automatic int expected_fills(input string op);
        return (op == "rh" || op == "wh") ? 0 : 1;
    endfunction

    function automatic int expected_writebacks(input string op);
        return (op == "rw") ? 1 : 0;
    endfunction

    // each word holds its own byte address until written back
    function automatic logic [`CACHE_LINE_W-1:0] memory_line(input logic [31:0] line_addr);
        logic [`CACHE_LINE_W-1:0] fill;
        fill = '0;
        if (wb_lines.exists(line_addr)) begin
            return wb_lines[line_addr];
        end
        for (int w = 0; w < `CACHE_LINE_BYTES / 4; w++) begin
            fill[w*32 +: 32] = line_addr + 32'(w * 4);
        end
        return fill;
    endfunction

    // memory port model driven on the falling edge
    always @(negedge clk) begin
        dfp_resp = 1'b0;
        if (rst || !(dfp_read || dfp_write)) begin
            mem_age = 0;
        end else begin
            mem_age = mem_age + 1;
            if (mem_age == MEM_DELAY) begin
                mem_age  = 0;
                dfp_resp = 1'b1;
                if (dfp_write) begin
                    wb_lines[dfp_addr] = dfp_wdata;
                    last_wb_addr       = dfp_addr;
                    wb_count++;
                end else begin
                    dfp_rdata = memory_line(dfp_addr);
                    fill_count++;
                end
            end
        end
    end

    task automatic read_vectors();
        int               fd;
        int               got;
        int               cnt;
        logic [8*160-1:0] text;
        logic [8*32-1:0]  name_tok;
        logic [8*32-1:0]  op_tok;
        logic [31:0]      f_addr;
        logic [31:0]      f_rmask;
        logic [31:0]      f_wmask;
        logic [31:0]      f_wdata;
        logic [31:0]      f_rdata;
        logic [31:0]      f_wbaddr;
        test_vec_t        v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test vector file %s", VEC_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                text     = '0;
                name_tok = '0;
                op_tok   = '0;
                cnt      = 0;
                got      = $fgets(text, fd);
                if (got > 0) begin
                    cnt = $sscanf(text, "%s %s %h %h %h %h %h %h", name_tok, op_tok,
                                  f_addr, f_rmask, f_wmask, f_wdata, f_rdata, f_wbaddr);
                end
                // comment lines start with a lone hash
                if (cnt > 0 && token_text(name_tok) != "#") begin
                    if (cnt != 8 || expected_latency(token_text(op_tok)) < 0) begin
                        $display("malformed line in the test vector file: %s",
                                 token_text(name_tok));
                        errors++;
                    end else begin
                        v.req.addr  = addr_fields_t'(f_addr);
                        v.req.rmask = f_rmask[3:0];
                        v.req.wmask = f_wmask[3:0];
                        v.req.wdata = f_wdata;
                        v.rdata     = f_rdata;
                        v.wbaddr    = f_wbaddr;
                        vecs.push_back(v);
                        names.push_back(token_text(name_tok));
                        ops.push_back(token_text(op_tok));
                    end
                end
            end
            $fclose(fd);
        end
        if (vecs.size() == 0) begin
            $display("no test vectors were read from %s", VEC_FILE);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d mismatches", name, errors - errs_before);
        end
        tests_run++;
    endtask

    // called right after a falling edge with the cache idle
    task automatic run_test(input int idx);
        test_vec_t v;
        string     name;
        string     op;
        int        waited;
        int        fills0;
        int        wbs0;
        int        errs0;
        logic      seen;
        v      = vecs[idx];
        name   = names[idx];
        op     = ops[idx];
        errs0  = errors;
        fills0 = fill_count;
        wbs0   = wb_count;
        ufp_addr  = v.req.addr;
        ufp_rmask = v.req.rmask;
        ufp_wmask = v.req.wmask;
        ufp_wdata = v.req.wdata;
        // request held until ufp_resp
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            waited++;
            seen = ufp_resp;
        end
        check_value(name, "rdata", v.rdata, ufp_rdata);
        // resp is taken at the rising edge after this sample
        check_value(name, "latency", 32'(expected_latency(op)), 32'(waited + 1));
        check_value(name, "line fills", 32'(expected_fills(op)), 32'(fill_count - fills0));
        check_value(name, "write-backs", 32'(expected_writebacks(op)), 32'(wb_count - wbs0));
        if (op == "rw") begin
            check_value(name, "write-back address", v.wbaddr, last_wb_addr);
        end
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        @(negedge clk);
        // single-cycle pulse
        check_value(name, "ufp_resp after pulse", '0, 32'(ufp_resp));
        report_test(name, errs0);
    endtask

    initial begin
        int errs_at_reset;
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        read_vectors();
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        errs_at_reset = errors;
        @(negedge clk);
        check_value("reset", "ufp_resp", '0, 32'(ufp_resp));
        check_value("reset", "dfp_read", '0, 32'(dfp_read));
        check_value("reset", "dfp_write", '0, 32'(dfp_write));
        report_test("reset", errs_at_reset);
        for (int i = 0; i < vecs.size(); i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // budget scales with the number of vectors read
    initial begin : watchdog
        wait (vectors_loaded);
        repeat ((vecs.size() + 1) * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk);
        $display("timeout, the cache stopped responding before all tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_control (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  cache_pkg::cache_req_t        req,
    input  wire logic                    hit,
    input  cache_pkg::way_idx_t          hit_way,
    input  cache_pkg::way_idx_t          victim_way,
    input  wire logic                    victim_dirty,
    input  cache_pkg::plru_t             plru_next,
    input  wire logic [`CACHE_TAG_W-1:0] victim_tag,
    input  cache_pkg::line_t             victim_line,
    input  cache_pkg::line_t             merge_line,
    input  cache_pkg::line_mask_t        merge_mask,
    input  wire logic [`CACHE_LINE_W-1:0] dfp_rdata,
    input  wire logic                    dfp_resp,
    output logic                         in_idle,
    output logic                         ufp_resp,
    output logic [31:0]                  dfp_addr,
    output logic                         dfp_read,
    output logic                         dfp_write,
    output logic [`CACHE_LINE_W-1:0]     dfp_wdata,
    output cache_pkg::way_write_t        wr
);
    import cache_pkg::*;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    assign in_idle = (state == s_idle);

    always_comb begin
        state_next = state;
        ufp_resp   = 1'b0;
        dfp_addr   = '0;
        dfp_read   = 1'b0;
        dfp_write  = 1'b0;
        dfp_wdata  = '0;
        wr         = '0;
        unique case (state)
            s_idle: begin
                // arrays read this cycle and compared in the next
                if ((req.rmask | req.wmask) != 4'b0000) begin
                    state_next = s_comp;
                end
            end
            s_comp: begin
                if (hit) begin
                    ufp_resp = 1'b1;
                    // write hit merges bytes and marks the line dirty
                    if (req.wmask != 4'b0000) begin
                        wr.en    = 1'b1;
                        wr.way   = hit_way;
                        wr.mask  = merge_mask;
                        wr.data  = merge_line;
                        wr.tag   = req.addr.tag;
                        wr.valid = 1'b1;
                        wr.dirty = 1'b1;
                    end
                    wr.plru_en = 1'b1;
                    wr.plru    = plru_next;
                    state_next = s_idle;
                end else if (victim_dirty) begin
                    state_next = s_wb;
                end else begin
                    state_next = s_alloc;
                end
            end
            s_alloc: begin
                // line fill from memory with the offset cleared
                dfp_read = 1'b1;
                dfp_addr = {req.addr.tag, req.addr.set, {`CACHE_OFS_W{1'b0}}};
                if (dfp_resp) begin
                    wr.en      = 1'b1;
                    wr.way     = victim_way;
                    wr.mask    = '1;
                    wr.data    = dfp_rdata;
                    wr.tag     = req.addr.tag;
                    wr.valid   = 1'b1;
                    wr.dirty   = 1'b0;
                    // idle again so the held request hits on its second lookup
                    state_next = s_idle;
                end
            end
            s_wb: begin
                // victim line out at its own address
                dfp_write = 1'b1;
                dfp_addr  = {victim_tag, req.addr.set, {`CACHE_OFS_W{1'b0}}};
                dfp_wdata = victim_line;
                if (dfp_resp) begin
                    state_next = s_alloc;
                end
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // memory request and its address held until dfp_resp
    a_dfp_hold: assert property (@(posedge clk) disable iff (rst)
        ((dfp_read || dfp_write) && !dfp_resp) |=>
            ($stable(dfp_read) && $stable(dfp_write) && $stable(dfp_addr)));

endmodule

`default_nettype wire

// ==== verilog/cache_hit_check.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_hit_check (
    input  cache_pkg::cache_req_t        req,
    input  wire logic [`CACHE_TAG_W-1:0] tags    [`CACHE_WAYS],
    input  wire logic                    valids  [`CACHE_WAYS],
    input  wire logic                    dirties [`CACHE_WAYS],
    input  cache_pkg::plru_t             plru,
    output logic                         hit,
    output cache_pkg::way_idx_t          hit_way,
    output cache_pkg::way_idx_t          victim_way,
    output logic                         victim_dirty,
    output cache_pkg::plru_t             plru_next
);
    import cache_pkg::*;

    logic [`CACHE_WAYS-1:0] hit_vec;

    // tag compare on valid ways
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = valids[w] && (tags[w] == req.addr.tag);
            if (hit_vec[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit = |hit_vec;

    // root picks the half, lower bit picks the way
    always_comb begin
        if (!plru[2]) begin
            victim_way = plru[1] ? 2'd1 : 2'd0;
        end else begin
            victim_way = plru[0] ? 2'd3 : 2'd2;
        end
    end

    // write-back needed only for a valid dirty victim
    assign victim_dirty = valids[victim_way] && dirties[victim_way];

    // point the tree away from the way just used
    always_comb begin
        unique case (hit_way)
            2'd0:    plru_next = {2'b11, plru[0]};
            2'd1:    plru_next = {2'b10, plru[0]};
            2'd2:    plru_next = {1'b0, plru[1], 1'b1};
            default: plru_next = {1'b0, plru[1], 1'b0};
        endcase
    end

    // fills always replace the victim, so a tag never lives in two ways of a set
    always_comb begin
        a_one_hit: assert ($onehot0(hit_vec) || $isunknown(hit_vec));
    end

endmodule

`default_nettype wire

// ==== verilog/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
`define CACHE_WAYS       4
`define CACHE_SETS       16

// address split: tag | set | byte offset
`define CACHE_TAG_W      23
`define CACHE_SET_W      4
`define CACHE_OFS_W      5

// one line, as moved on the memory port
`define CACHE_LINE_W     256
`define CACHE_LINE_BYTES 32

`endif

// ==== verilog/cache_pkg.sv ====
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic [`CACHE_SET_W-1:0] set;
        logic [`CACHE_OFS_W-1:0] ofs;
    } addr_fields_t;

    // cpu request, as held by the cpu until ufp_resp
    typedef struct packed {
        addr_fields_t addr;
        logic [3:0]   rmask;
        logic [3:0]   wmask;
        logic [31:0]  wdata;
    } cache_req_t;

    typedef logic [`CACHE_LINE_W-1:0]     line_t;
    typedef logic [`CACHE_LINE_BYTES-1:0] line_mask_t;
    typedef logic [1:0]                   way_idx_t;
    // tree bits: [2] root, [1] ways 0/1, [0] ways 2/3
    typedef logic [2:0]                   plru_t;

    typedef enum logic [1:0] {
        s_idle,
        s_comp,
        s_alloc,
        s_wb
    } state_t;

    // one store write; way fields and plru bits go to the same set
    typedef struct packed {
        logic                    en;
        way_idx_t                way;
        line_mask_t              mask;
        line_t                   data;
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
        logic                    dirty;
        logic                    plru_en;
        plru_t                   plru;
    } way_write_t;

endpackage

`default_nettype wire

// ==== verilog/cache_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_req_decode (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [31:0]             ufp_addr,
    input  wire logic [3:0]              ufp_rmask,
    input  wire logic [3:0]              ufp_wmask,
    input  wire logic [31:0]             ufp_wdata,
    input  wire logic                    in_idle,
    output cache_pkg::cache_req_t        req,
    output logic [`CACHE_SET_W-1:0]      rd_set
);
    import cache_pkg::*;

    cache_req_t live_req;
    cache_req_t req_q;

    // live request split into fields
    always_comb begin
        live_req.addr  = addr_fields_t'(ufp_addr);
        live_req.rmask = ufp_rmask;
        live_req.wmask = ufp_wmask;
        live_req.wdata = ufp_wdata;
    end

    // capture on every idle cycle, hold while busy
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else if (in_idle) begin
            req_q <= live_req;
        end
    end

    // idle shows the live request so the controller sees it arrive
    assign req = in_idle ? live_req : req_q;

    // register not loaded yet while idle, so read set comes from the pins
    assign rd_set = in_idle ? live_req.addr.set : req_q.addr.set;

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    // cpu port
    input  wire logic [31:0]              ufp_addr,
    input  wire logic [3:0]               ufp_rmask,
    input  wire logic [3:0]               ufp_wmask,
    output logic [31:0]                   ufp_rdata,
    input  wire logic [31:0]              ufp_wdata,
    output logic                          ufp_resp,
    // memory port
    output logic [31:0]                   dfp_addr,
    output logic                          dfp_read,
    output logic                          dfp_write,
    input  wire logic [`CACHE_LINE_W-1:0] dfp_rdata,
    output logic [`CACHE_LINE_W-1:0]      dfp_wdata,
    input  wire logic                     dfp_resp
);

    cache_pkg::cache_req_t   req;
    logic [`CACHE_SET_W-1:0] rd_set;
    logic                    in_idle;
    cache_pkg::way_write_t   wr;
    logic [`CACHE_TAG_W-1:0] tags    [`CACHE_WAYS];
    cache_pkg::line_t        lines   [`CACHE_WAYS];
    logic                    valids  [`CACHE_WAYS];
    logic                    dirties [`CACHE_WAYS];
    cache_pkg::plru_t        plru;
    cache_pkg::plru_t        plru_next;
    logic                    hit;
    logic                    victim_dirty;
    cache_pkg::way_idx_t     hit_way;
    cache_pkg::way_idx_t     victim_way;
    logic [`CACHE_TAG_W-1:0] victim_tag;
    cache_pkg::line_t        victim_line;
    cache_pkg::line_t        hit_line;
    cache_pkg::line_t        merge_line;
    cache_pkg::line_mask_t   merge_mask;

    // way select for the hit and victim lines
    assign hit_line    = lines[hit_way];
    assign victim_line = lines[victim_way];
    assign victim_tag  = tags[victim_way];

    cache_req_decode cache_req_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .in_idle   (in_idle),
        .req       (req),
        .rd_set    (rd_set)
    );

    cache_way_store cache_way_store_inst (
        .clk     (clk),
        .rst     (rst),
        .rd_set  (rd_set),
        .wr      (wr),
        .tags    (tags),
        .lines   (lines),
        .valids  (valids),
        .dirties (dirties),
        .plru    (plru)
    );

    cache_hit_check cache_hit_check_inst (
        .req          (req),
        .tags         (tags),
        .valids       (valids),
        .dirties      (dirties),
        .plru         (plru),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .plru_next    (plru_next)
    );

    cache_word_io cache_word_io_inst (
        .req        (req),
        .hit_line   (hit_line),
        .rdata      (ufp_rdata),
        .merge_line (merge_line),
        .merge_mask (merge_mask)
    );

    cache_control cache_control_inst (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .plru_next    (plru_next),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .merge_line   (merge_line),
        .merge_mask   (merge_mask),
        .dfp_rdata    (dfp_rdata),
        .dfp_resp     (dfp_resp),
        .in_idle      (in_idle),
        .ufp_resp     (ufp_resp),
        .dfp_addr     (dfp_addr),
        .dfp_read     (dfp_read),
        .dfp_write    (dfp_write),
        .dfp_wdata    (dfp_wdata),
        .wr           (wr)
    );

endmodule

`default_nettype wire

// ==== verilog/cache_way_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_way_store (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [`CACHE_SET_W-1:0] rd_set,
    input  cache_pkg::way_write_t        wr,
    output logic [`CACHE_TAG_W-1:0]      tags    [`CACHE_WAYS],
    output cache_pkg::line_t             lines   [`CACHE_WAYS],
    output logic                         valids  [`CACHE_WAYS],
    output logic                         dirties [`CACHE_WAYS],
    output cache_pkg::plru_t             plru
);
    import cache_pkg::*;

    logic [`CACHE_TAG_W-1:0] tag_mem   [`CACHE_SETS][`CACHE_WAYS];
    line_t                   data_mem  [`CACHE_SETS][`CACHE_WAYS];
    logic                    valid_mem [`CACHE_SETS][`CACHE_WAYS];
    logic                    dirty_mem [`CACHE_SETS][`CACHE_WAYS];
    plru_t                   plru_mem  [`CACHE_SETS];
    // set whose contents sit on the outputs
    logic [`CACHE_SET_W-1:0] set_q;

    // tag and data, no reset
    always_ff @(posedge clk) begin
        if (wr.en) begin
            tag_mem[rd_set][wr.way] <= wr.tag;
            // byte lanes under the write mask
            for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
                if (wr.mask[b]) begin
                    data_mem[rd_set][wr.way][b*8 +: 8] <= wr.data[b*8 +: 8];
                end
            end
        end
        // registered read, one cycle latency
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            tags[w]  <= tag_mem[rd_set][w];
            lines[w] <= data_mem[rd_set][w];
        end
        set_q <= rd_set;
    end

    // status bits and plru
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '{default: '{default: 1'b0}};
            dirty_mem <= '{default: '{default: 1'b0}};
            plru_mem  <= '{default: '0};
            valids    <= '{default: 1'b0};
            dirties   <= '{default: 1'b0};
            plru      <= '0;
        end else begin
            if (wr.en) begin
                valid_mem[rd_set][wr.way] <= wr.valid;
                dirty_mem[rd_set][wr.way] <= wr.dirty;
            end
            if (wr.plru_en) begin
                plru_mem[rd_set] <= wr.plru;
            end
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valids[w]  <= valid_mem[rd_set][w];
                dirties[w] <= dirty_mem[rd_set][w];
            end
            plru <= plru_mem[rd_set];
        end
    end

    // way and plru writes land on the set that was read the cycle before
    a_write_set: assert property (@(posedge clk) disable iff (rst)
        (wr.en || wr.plru_en) |-> (rd_set == set_q));

endmodule

`default_nettype wire

// ==== verilog/cache_word_io.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cache_word_io (
    input  cache_pkg::cache_req_t   req,
    input  cache_pkg::line_t        hit_line,
    output logic [31:0]             rdata,
    output cache_pkg::line_t        merge_line,
    output cache_pkg::line_mask_t   merge_mask
);
    import cache_pkg::*;

    // word slot within the line
    logic [`CACHE_OFS_W-3:0] word_idx;
    logic [31:0]             word;

    assign word_idx = req.addr.ofs[`CACHE_OFS_W-1:2];
    assign word     = hit_line[word_idx*32 +: 32];

    // bytes outside rmask read as zero
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rdata[b*8 +: 8] = req.rmask[b] ? word[b*8 +: 8] : 8'h00;
        end
    end

    // wdata goes in its slot, only the wmask bytes get written
    always_comb begin
        merge_line = '0;
        merge_mask = '0;
        merge_line[word_idx*32 +: 32] = req.wdata;
        merge_mask[word_idx*4 +: 4]   = req.wmask;
    end

endmodule

`default_nettype wire
